//--- hdl/ldpc_fill_pkg.sv
// LDPC fill preprocessor shared definitions
// Frame geometry of the CCSDS (8160,7136) code for an 8-bit stream and
// the per-byte plan that steers the bit packer

`default_nettype none

package ldpc_fill_pkg;

  // ******************************************************************
  // Frame geometry
  // ******************************************************************
  localparam int DATA_W         = 8;
  localparam int INFO_BITS      = 7136;
  localparam int FILL_BITS      = 18;     // Virtual fill ahead of the info bits
  localparam int SUB_BLOCK_BITS = 512;    // Last bit is the pad

  localparam int IN_BYTES      = INFO_BITS / DATA_W;                         // 892
  localparam int NUM_SUB       = (INFO_BITS + FILL_BITS) / (SUB_BLOCK_BITS - 1);
  localparam int BYTES_PER_SUB = SUB_BLOCK_BITS / DATA_W;                    // 64
  localparam int OUT_BYTES     = NUM_SUB * BYTES_PER_SUB;                    // 896

  localparam int CNT_W      = $clog2(OUT_BYTES);
  localparam int SUB_IDX_W  = $clog2(BYTES_PER_SUB);
  localparam int FILL_W     = $clog2(FILL_BITS + 1);
  localparam int PLAN_CNT_W = 4;

  // ******************************************************************
  // Per-byte plan of fill zeros, info bits and pad from the MSB down
  // ******************************************************************
  typedef struct packed {
    logic [PLAN_CNT_W-1:0] fill_cnt;
    logic [PLAN_CNT_W-1:0] info_cnt;
    logic                  pad;       // LSB is a sub-block pad zero
  } byte_plan_t;

endpackage

`default_nettype wire

//--- hdl/fill_planner.sv
// Fill planner
// Counts output bytes within a frame and tracks how many virtual fill
// bits are still owed. Presents a registered plan for the next output
// byte and steps to the following byte on each byte_done pulse.

`timescale 1ns/1ns
`default_nettype none

module fill_planner
  import ldpc_fill_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_done,
  output byte_plan_t plan
);

  logic [CNT_W-1:0]  byte_cnt;
  logic [FILL_W-1:0] fill_left;   // Fill bits not yet emitted
  logic              last_byte;
  logic [CNT_W-1:0]  nxt_cnt;
  logic [FILL_W-1:0] nxt_fill;

  // Plan for byte idx given the fill bits still owed before it
  function automatic byte_plan_t make_plan(input logic [CNT_W-1:0]  idx,
                                           input logic [FILL_W-1:0] owed);
    byte_plan_t            p;
    logic [PLAN_CNT_W-1:0] slots;
    begin
      p.pad = &idx[SUB_IDX_W-1:0];   // Last byte of a sub-block
      slots = p.pad ? PLAN_CNT_W'(DATA_W - 1) : PLAN_CNT_W'(DATA_W);
      if (owed > FILL_W'(slots))
      begin
        p.fill_cnt = slots;
      end
      else
      begin
        p.fill_cnt = PLAN_CNT_W'(owed);
      end
      p.info_cnt = slots - p.fill_cnt;
      return p;
    end
  endfunction

  // ******************************************************************
  // Next byte position
  // ******************************************************************
  always_comb
  begin
    last_byte = byte_cnt == CNT_W'(OUT_BYTES - 1);
    nxt_cnt   = last_byte ? '0 : byte_cnt + 1'b1;
    // New frame owes the full fill again
    nxt_fill  = last_byte ? FILL_W'(FILL_BITS) : fill_left - FILL_W'(plan.fill_cnt);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      byte_cnt  <= '0;
      fill_left <= FILL_W'(FILL_BITS);
      plan      <= make_plan('0, FILL_W'(FILL_BITS));
    end
    else if (byte_done)
    begin
      byte_cnt  <= nxt_cnt;
      fill_left <= nxt_fill;
      plan      <= make_plan(nxt_cnt, nxt_fill);
    end
  end

  // Every planned byte is exactly one stream byte wide
  a_plan_width: assert property (@(posedge clk) disable iff (!rst_n)
    (32'(plan.fill_cnt) + 32'(plan.info_cnt) + 32'(plan.pad)) == DATA_W);

endmodule

`default_nettype wire

//--- hdl/bit_packer.sv
// Bit packer
// Holds the unused tail of the last input byte and builds each output
// byte from the current plan as fill zeros, then info bits taken from
// the leftovers first and then from the new input byte, then an optional
// pad zero. Valid/ready on both sides; output held under back-pressure.

`timescale 1ns/1ns
`default_nettype none

module bit_packer
  import ldpc_fill_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  byte_plan_t        plan,
  input  logic [DATA_W-1:0] s_data,
  input  logic              s_valid,
  output logic              s_ready,
  output logic [DATA_W-1:0] m_data,
  output logic              m_valid,
  input  logic              m_ready,
  output logic              byte_done
);

  logic [DATA_W-2:0]     left_bits;   // Unused bits kept LSB aligned
  logic [PLAN_CNT_W-1:0] left_cnt;

  logic                  slot_free;
  logic                  need_input;
  logic                  in_fire;
  logic                  load;

  logic [2*DATA_W-1:0]   pool;
  logic [2*DATA_W-1:0]   shifted;
  logic [2*DATA_W-1:0]   info_mask;
  logic [PLAN_CNT_W:0]   shamt;
  logic [DATA_W-1:0]     info_byte;
  logic [DATA_W-1:0]     next_byte;
  logic [PLAN_CNT_W-1:0] next_left_cnt;

  // ******************************************************************
  // Handshake control
  // ******************************************************************
  assign slot_free  = !m_valid || m_ready;
  assign need_input = left_cnt < plan.info_cnt;
  assign s_ready    = slot_free && need_input;
  assign in_fire    = s_valid && s_ready;
  assign load       = slot_free && (!need_input || in_fire);
  assign byte_done  = load;

  // ******************************************************************
  // Byte assembly
  // ******************************************************************
  always_comb
  begin
    // Leftovers sit directly above the new byte, oldest bit highest
    pool      = {1'b0, left_bits, s_data};
    shamt     = (PLAN_CNT_W + 1)'(DATA_W) + {1'b0, left_cnt} - {1'b0, plan.info_cnt};
    shifted   = pool >> shamt;
    info_mask = ~({(2 * DATA_W){1'b1}} << plan.info_cnt);
    info_byte = shifted[DATA_W-1:0] & info_mask[DATA_W-1:0];  // Fill zeros on top
    next_byte = plan.pad ? {info_byte[DATA_W-2:0], 1'b0} : info_byte;

    if (need_input)
    begin
      next_left_cnt = left_cnt + PLAN_CNT_W'(DATA_W) - plan.info_cnt;
    end
    else
    begin
      next_left_cnt = left_cnt - plan.info_cnt;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      m_valid  <= 1'b0;
      left_cnt <= '0;
    end
    else if (load)
    begin
      m_valid  <= 1'b1;
      left_cnt <= next_left_cnt;
    end
    else if (m_ready)
    begin
      m_valid  <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      m_data <= next_byte;
    end
    if (in_fire)
    begin
      left_bits <= s_data[DATA_W-2:0];  // Top bit is always consumed
    end
  end

  a_left_max: assert property (@(posedge clk) disable iff (!rst_n)
    left_cnt <= PLAN_CNT_W'(DATA_W - 1));

  // Waiting byte must not change
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

//--- hdl/ldpc_fill_top.sv
// LDPC fill preprocessor top level
// Takes 892 info bytes per frame and emits 896 bytes: 18 leading fill
// zeros, the info bits, and a zero pad after every 511 bits.
// The planner steps through output bytes, the packer moves the data.

`timescale 1ns/1ns
`default_nettype none

module ldpc_fill_top
  import ldpc_fill_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] s_data,
  input  logic              s_valid,
  output logic              s_ready,
  output logic [DATA_W-1:0] m_data,
  output logic              m_valid,
  input  logic              m_ready
);

  byte_plan_t plan;
  logic       byte_done;   // Planner advance strobe

  fill_planner planner_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_done (byte_done),
    .plan      (plan)
  );

  bit_packer packer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .plan      (plan),
    .s_data    (s_data),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .m_data    (m_data),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .byte_done (byte_done)
  );

endmodule

`default_nettype wire

//--- tb/ldpc_fill_tb.sv
// LDPC fill preprocessor testbench
// Reads one test per line from the stimulus file and streams random info
// bytes through the DUT with input gaps and output stalls. Every output
// byte is checked against a bit-level model of the fill and pad rules.

`timescale 1ns/1ns
`default_nettype none

module ldpc_fill_tb
  import ldpc_fill_pkg::*;
();

  localparam int CYCLE_MARGIN = 2000;

  logic              clk;
  logic              rst_n;
  logic [DATA_W-1:0] s_data;
  logic              s_valid;
  logic              s_ready;
  logic [DATA_W-1:0] m_data;
  logic              m_valid;
  logic              m_ready;

  // Test list columns
  int test_id[$];
  int data_seed[$];
  int gap_rate[$];
  int stall_rate[$];
  int frame_cnt[$];
  int bytes_per_frame[$];

  logic [DATA_W-1:0] in_q[$];
  logic [DATA_W-1:0] exp_q[$];

  int checks;
  int errors;
  int cycles;
  int cycle_limit;

  ldpc_fill_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_data  (s_data),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_data  (m_data),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("Run stopped after %0d cycles, the DUT did not deliver all frames", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, msg, actual, expected);
    end
  endtask

  // ******************************************************************
  // Test list and reference model
  // ******************************************************************
  task automatic read_tests();
    int    fd;
    int    r;
    int    id;
    int    seed;
    int    gap;
    int    stall;
    int    frames;
    int    nbytes;
    string line;
    fd = $fopen("tb/ldpc_fill_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file tb/ldpc_fill_stim.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        r = $fgets(line, fd);
        if (r > 0 && line[0] != "#")
        begin
          r = $sscanf(line, "%d %h %d %d %d %d", id, seed, gap, stall, frames, nbytes);
          if (r == 6)
          begin
            test_id.push_back(id);
            data_seed.push_back(seed);
            gap_rate.push_back(gap);
            stall_rate.push_back(stall);
            frame_cnt.push_back(frames);
            bytes_per_frame.push_back(nbytes);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // 18 zeros, then info bits MSB first, a zero after every 511 bits
  task automatic build_expected(input int frames);
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] src;
    logic              b;
    int                obit;
    int                ib;
    for (int f = 0; f < frames; f++)
    begin
      obit = 0;
      acc  = '0;
      for (int k = 0; k < FILL_BITS + INFO_BITS; k++)
      begin
        if (k < FILL_BITS)
        begin
          b = 1'b0;
        end
        else
        begin
          ib  = k - FILL_BITS;
          src = in_q[f * IN_BYTES + ib / DATA_W] << (ib % DATA_W);
          b   = src[DATA_W-1];
        end
        acc = {acc[DATA_W-2:0], b};
        obit++;
        if (obit % SUB_BLOCK_BITS == SUB_BLOCK_BITS - 1)
        begin
          acc = {acc[DATA_W-2:0], 1'b0};  // Pad bit
          obit++;
        end
        if (obit % DATA_W == 0)
        begin
          exp_q.push_back(acc);
        end
      end
    end
  endtask

  task automatic apply_reset();
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    m_ready = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // ******************************************************************
  // One test driven on the falling edge and sampled 1 ns later
  // ******************************************************************
  task automatic run_test(input int t);
    int                total_in;
    int                total_out;
    int                in_idx;
    int                out_idx;
    int                in_mark;
    int                pos;
    int                err_start;
    logic              in_fire;
    logic              held;
    logic [DATA_W-1:0] held_data;
    in_q.delete();
    exp_q.delete();
    total_in  = frame_cnt[t] * IN_BYTES;
    total_out = frame_cnt[t] * bytes_per_frame[t];
    for (int i = 0; i < total_in; i++)
    begin
      in_q.push_back(8'($urandom) ^ 8'(data_seed[t]));
    end
    build_expected(frame_cnt[t]);
    check_equal(32'(exp_q.size()), 32'(total_out), "model length against test line");
    err_start = errors;
    in_idx    = 0;
    out_idx   = 0;
    in_mark   = 0;
    in_fire   = 1'b0;
    held      = 1'b0;
    apply_reset();
    while (out_idx < total_out)
    begin
      @(negedge clk);
      if (in_fire)
      begin
        s_valid = 1'b0;
      end
      m_ready = int'($urandom % 100) >= stall_rate[t];
      if (!s_valid && in_idx < total_in && int'($urandom % 100) >= gap_rate[t])
      begin
        s_valid = 1'b1;
        s_data  = in_q[in_idx];
      end
      #1;
      if (held)
      begin
        check_equal(32'(m_valid), 32'd1, "valid dropped while waiting");
        check_equal(32'(m_data), 32'(held_data), "byte changed while waiting");
      end
      held      = m_valid && !m_ready;
      held_data = m_data;
      in_fire   = s_valid && s_ready;
      if (in_fire)
      begin
        in_idx++;
      end
      if (m_valid && m_ready)
      begin
        pos = out_idx % bytes_per_frame[t];
        check_equal(32'(m_data), 32'(exp_q[out_idx]), "output byte against model");
        if (pos < 2)
        begin
          check_equal(32'(m_data), 32'd0, "leading fill byte");
        end
        if (pos == 2)
        begin
          check_equal(32'(m_data[DATA_W-1 -: 2]), 32'd0, "fill bits of byte 2");
        end
        if (pos % BYTES_PER_SUB == BYTES_PER_SUB - 1)
        begin
          check_equal(32'(m_data[0]), 32'd0, "sub-block pad bit");
        end
        if (pos == bytes_per_frame[t] - 1)
        begin
          check_equal(32'(in_idx - in_mark), 32'(IN_BYTES), "input bytes per frame");
          in_mark = in_idx;
        end
        out_idx++;
      end
    end
    check_equal(32'(in_idx), 32'(total_in), "input bytes per test");
    $display("test %0d: %0d frames, %0d bytes in, %0d bytes out, %0d errors",
             test_id[t], frame_cnt[t], in_idx, out_idx, errors - err_start);
  endtask

  initial
  begin
    int total_frames;
    rst_n        = 1'b0;
    s_valid      = 1'b0;
    s_data       = '0;
    m_ready      = 1'b0;
    checks       = 0;
    errors       = 0;
    total_frames = 0;
    void'($urandom(32'hee83));
    read_tests();
    foreach (frame_cnt[i])
    begin
      total_frames += frame_cnt[i];
    end
    cycle_limit = total_frames * OUT_BYTES * 4 + CYCLE_MARGIN;
    for (int t = 0; t < test_id.size(); t++)
    begin
      run_test(t);
    end
    $display("tests %0d, checks %0d, errors %0d", test_id.size(), checks, errors);
    if (errors == 0 && test_id.size() > 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/ldpc_fill_stim.txt
# Columns: test id, data seed (hex), input gap rate %, output stall rate %,
#          frames, expected output bytes per frame
1 00 0 0 1 896
2 5a 0 30 1 896
3 c3 30 0 1 896
4 17 25 25 3 896
5 e1 10 40 2 896
6 ff 0 0 2 896

//--- project.f
hdl/ldpc_fill_pkg.sv
hdl/fill_planner.sv
hdl/bit_packer.sv
hdl/ldpc_fill_top.sv
tb/ldpc_fill_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LDPC fill testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module ldpc_fill_tb -f project.f -o ldpc_fill_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/ldpc_fill_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
